/* rtl/c16_config.svh */
`ifndef C16_CONFIG_SVH
`define C16_CONFIG_SVH

// Datapath and storage sizes
`define C16_WORD_W      16
`define C16_REG_AW      3
`define C16_MEM_AW      8
`define C16_MEM_DEPTH   256
`define C16_SCRATCH_REG 3'd7

// Major opcode in instr[15:12] with the form flag in instr[11]
`define C16_OP_ADD 4'b0000
`define C16_OP_SUB 4'b0001
`define C16_OP_SLT 4'b0010
`define C16_OP_SHL 4'b1000
`define C16_OP_LD  4'b1010
`define C16_OP_ST  4'b1011
`define C16_OP_LEA 4'b1100

// APB byte address map
`define C16_APB_AW       10
`define C16_APB_MEM      10'h000
`define C16_APB_REG      10'h200
`define C16_APB_CTRL     10'h300
`define C16_APB_MEM_MASK 10'h200
`define C16_APB_SEL_MASK 10'h300

`endif

/* rtl/c16_pkg.sv */
`include "c16_config.svh"

package c16_pkg;

	// Plain vectors with a meaning
	typedef logic [`C16_WORD_W-1:0] word_t;
	typedef logic [`C16_REG_AW-1:0] reg_addr_t;
	typedef logic [`C16_MEM_AW-1:0] mem_addr_t;

	// Operation carried from decode into execute
	typedef enum logic [2:0] {
		EX_NOP,
		EX_ADD,
		EX_SUB,
		EX_SLT,
		EX_SHL,
		EX_LOAD,
		EX_STORE
	} exec_op_e;

	typedef enum logic {
		DEC_RUN,
		DEC_LOAD_WAIT
	} decode_state_e;

	typedef struct packed {
		word_t pc;
		logic  valid;
	} fetch_t;

	typedef struct packed {
		exec_op_e  op;
		word_t     arg_0;
		word_t     arg_1;
		word_t     store_data;
		reg_addr_t dest;
	} issue_t;

	// Register file write-back
	typedef struct packed {
		logic      en;
		reg_addr_t dest;
		word_t     value;
	} wb_t;

	// Core side of memory port B
	typedef struct packed {
		logic      rd;
		logic      wr;
		mem_addr_t addr;
		word_t     wdata;
	} mem_req_t;

endpackage

/* rtl/c16_fetch.sv */
`timescale 1ns/1ps

module c16_fetch (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               run,
	input  logic               stall,
	output c16_pkg::mem_addr_t next_pc,
	output c16_pkg::fetch_t    fetch
);

	c16_pkg::word_t pc_q;
	c16_pkg::word_t pc_d;
	logic           valid_q;
	logic           advance;

	assign advance = run & ~stall;
	assign pc_d    = advance ? pc_q + 1'b1 : pc_q;

	// The memory registers the port A address
	assign next_pc = c16_pkg::mem_addr_t'(pc_d);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_q    <= '1;
			valid_q <= 1'b0;
		end else begin
			pc_q <= pc_d;
			// A stalled word is read again at the same address and stays valid
			valid_q <= run & (advance | valid_q);
		end
	end

	assign fetch = '{pc: pc_q, valid: valid_q};

endmodule

/* rtl/c16_decode.sv */
`timescale 1ns/1ps
`include "c16_config.svh"

module c16_decode (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                run,
	input  c16_pkg::fetch_t     fetch,
	input  c16_pkg::word_t      instr,
	output c16_pkg::reg_addr_t  rs_addr,
	output c16_pkg::reg_addr_t  rt_addr,
	input  c16_pkg::word_t      rs_val,
	input  c16_pkg::word_t      rt_val,
	output logic                stall,
	output c16_pkg::issue_t     issue
);

	logic [3:0]                 major;
	logic                       form;
	c16_pkg::reg_addr_t         rd;
	c16_pkg::word_t             imm5;
	c16_pkg::word_t             imm8;
	c16_pkg::word_t             mem_base;
	c16_pkg::word_t             mem_offset;
	logic                       take;
	c16_pkg::decode_state_e     state_q;
	c16_pkg::exec_op_e          op_d;
	c16_pkg::exec_op_e          op_q;
	c16_pkg::word_t             arg_0_d;
	c16_pkg::word_t             arg_1_d;
	c16_pkg::word_t             arg_0_q;
	c16_pkg::word_t             arg_1_q;
	c16_pkg::word_t             store_q;
	c16_pkg::reg_addr_t         dest_q;

	////////////////////////////////////////////////////////////////////////////
	// Instruction fields
	////////////////////////////////////////////////////////////////////////////

	assign major = instr[15:12];
	assign form  = instr[11];
	assign rd    = instr[10:8];
	assign imm5  = {{(`C16_WORD_W-5){instr[4]}}, instr[4:0]};
	assign imm8  = {{(`C16_WORD_W-8){instr[7]}}, instr[7:0]};

	assign rs_addr = instr[7:5];
	// Store data comes from rd on the second port
	assign rt_addr = (major == `C16_OP_ST) ? rd : instr[2:0];

	// lea, ld and st address operands
	assign mem_base   = form ? fetch.pc : rs_val;
	assign mem_offset = form ? imm8 : imm5;

	assign stall = (state_q == c16_pkg::DEC_LOAD_WAIT);
	assign take  = run & fetch.valid & ~stall;

	always_comb begin
		op_d    = c16_pkg::EX_NOP;
		arg_0_d = rs_val;
		arg_1_d = form ? rt_val : imm5;
		case (major)
			`C16_OP_ADD: op_d = c16_pkg::EX_ADD;
			`C16_OP_SUB: op_d = c16_pkg::EX_SUB;
			`C16_OP_SLT: op_d = c16_pkg::EX_SLT;
			`C16_OP_SHL: begin
				// Both forms shift by the immediate
				op_d    = c16_pkg::EX_SHL;
				arg_1_d = imm5;
			end
			`C16_OP_LEA: begin
				op_d    = c16_pkg::EX_ADD;
				arg_0_d = mem_base;
				arg_1_d = mem_offset;
			end
			`C16_OP_LD: begin
				op_d    = c16_pkg::EX_LOAD;
				arg_0_d = mem_base;
				arg_1_d = mem_offset;
			end
			`C16_OP_ST: begin
				op_d    = c16_pkg::EX_STORE;
				arg_0_d = mem_base;
				arg_1_d = mem_offset;
			end
			default: op_d = c16_pkg::EX_NOP;
		endcase
		// Bubble when halted, when the word is stale, or behind a load
		if (!take) begin
			op_d = c16_pkg::EX_NOP;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Load wait FSM and issue register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= c16_pkg::DEC_RUN;
			op_q    <= c16_pkg::EX_NOP;
		end else begin
			op_q <= op_d;
			case (state_q)
				c16_pkg::DEC_RUN: begin
					if (op_d == c16_pkg::EX_LOAD) begin
						state_q <= c16_pkg::DEC_LOAD_WAIT;
					end
				end
				default: state_q <= c16_pkg::DEC_RUN;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		arg_0_q <= arg_0_d;
		arg_1_q <= arg_1_d;
		store_q <= rt_val;
		dest_q  <= rd;
	end

	assign issue = '{op: op_q, arg_0: arg_0_q, arg_1: arg_1_q,
		store_data: store_q, dest: dest_q};

endmodule

/* rtl/c16_execute.sv */
`timescale 1ns/1ps
`include "c16_config.svh"

module c16_execute (
	input  logic              clk,
	input  logic              rst_n,
	input  c16_pkg::issue_t   issue,
	input  c16_pkg::word_t    mem_rdata,
	output c16_pkg::wb_t      wb,
	output c16_pkg::mem_req_t mem_req
);

	c16_pkg::word_t     sum;
	c16_pkg::word_t     alu;
	logic               alu_en;
	logic               load_pend_q;
	c16_pkg::reg_addr_t load_dest_q;

	assign sum = issue.arg_0 + issue.arg_1;

	always_comb begin
		alu_en = 1'b1;
		case (issue.op)
			c16_pkg::EX_ADD: alu = sum;
			c16_pkg::EX_SUB: alu = issue.arg_0 - issue.arg_1;
			// unsigned compare
			c16_pkg::EX_SLT: alu = {{(`C16_WORD_W-1){1'b0}}, issue.arg_0 < issue.arg_1};
			c16_pkg::EX_SHL: alu = issue.arg_0 << issue.arg_1[3:0];
			default: begin
				alu    = sum;
				alu_en = 1'b0;
			end
		endcase
	end

	// Address is the low byte of base plus offset
	assign mem_req = '{rd: issue.op == c16_pkg::EX_LOAD, wr: issue.op == c16_pkg::EX_STORE,
		addr: c16_pkg::mem_addr_t'(sum), wdata: issue.store_data};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			load_pend_q <= 1'b0;
		end else begin
			load_pend_q <= (issue.op == c16_pkg::EX_LOAD) && (issue.dest != `C16_SCRATCH_REG);
		end
	end

	always_ff @(posedge clk) begin
		load_dest_q <= issue.dest;
	end

	// Load data lands while decode holds a bubble in execute
	assign wb = load_pend_q ? '{en: 1'b1, dest: load_dest_q, value: mem_rdata}
		: '{en: alu_en, dest: issue.dest, value: alu};

endmodule

/* rtl/c16_regfile.sv */
`timescale 1ns/1ps
`include "c16_config.svh"

module c16_regfile (
	input  logic               clk,
	input  logic               rst_n,
	input  c16_pkg::reg_addr_t rs_addr,
	input  c16_pkg::reg_addr_t rt_addr,
	input  c16_pkg::reg_addr_t dbg_addr,
	input  c16_pkg::wb_t       wb,
	output c16_pkg::word_t     rs_val,
	output c16_pkg::word_t     rt_val,
	output c16_pkg::word_t     dbg_val
);

	localparam int NUM_REGS = 1 << `C16_REG_AW;

	c16_pkg::word_t regs_q [NUM_REGS];
	logic           wr_en;

	// Scratch register never takes a write
	assign wr_en = wb.en && (wb.dest != `C16_SCRATCH_REG);

	// Same cycle write-back wins over the stored word
	function automatic c16_pkg::word_t read_port(input c16_pkg::reg_addr_t addr,
		input c16_pkg::word_t stored, input c16_pkg::wb_t wb_in);
		c16_pkg::word_t val;
		val = stored;
		if (wb_in.en && wb_in.dest == addr && addr != `C16_SCRATCH_REG) begin
			val = wb_in.value;
		end
		return val;
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs_q[i] <= '0;
			end
		end else if (wr_en) begin
			regs_q[wb.dest] <= wb.value;
		end
	end

	assign rs_val  = read_port(rs_addr, regs_q[rs_addr], wb);
	assign rt_val  = read_port(rt_addr, regs_q[rt_addr], wb);
	assign dbg_val = read_port(dbg_addr, regs_q[dbg_addr], wb);

endmodule

/* rtl/c16_mem.sv */
`timescale 1ns/1ps
`include "c16_config.svh"

module c16_mem (
	input  logic               clk,
	input  c16_pkg::mem_addr_t a_addr,
	output c16_pkg::word_t     a_data,
	input  c16_pkg::mem_addr_t b_addr,
	input  logic               b_wr,
	input  c16_pkg::word_t     b_wdata,
	output c16_pkg::word_t     b_data
);

	c16_pkg::word_t mem_q [`C16_MEM_DEPTH];

	// Port A, instruction fetch, read only
	always_ff @(posedge clk) begin
		a_data <= mem_q[a_addr];
	end

	// Port B returns the old word on a write
	always_ff @(posedge clk) begin
		if (b_wr) begin
			mem_q[b_addr] <= b_wdata;
		end
		b_data <= mem_q[b_addr];
	end

endmodule

/* rtl/c16_host_port.sv */
`timescale 1ns/1ps
`include "c16_config.svh"

module c16_host_port (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [`C16_APB_AW-1:0] paddr,
	input  c16_pkg::word_t         pwdata,
	output c16_pkg::word_t         prdata,
	output logic                   pready,
	output logic                   run,
	input  c16_pkg::mem_req_t      core_req,
	output c16_pkg::word_t         rdata,
	output c16_pkg::mem_addr_t     b_addr,
	output logic                   b_wr,
	output c16_pkg::word_t         b_wdata,
	input  c16_pkg::word_t         b_data,
	output c16_pkg::reg_addr_t     dbg_addr,
	input  c16_pkg::word_t         dbg_val
);

	logic access;
	logic is_mem;
	logic is_reg;
	logic is_ctrl;
	logic core_busy;
	logic grant;
	logic rd_pend_q;
	logic run_q;

	////////////////////////////////////////////////////////////////////////////
	// APB decode
	////////////////////////////////////////////////////////////////////////////

	assign access  = psel & penable;
	assign is_mem  = (paddr & `C16_APB_MEM_MASK) == `C16_APB_MEM;
	assign is_reg  = (paddr & `C16_APB_SEL_MASK) == `C16_APB_REG;
	assign is_ctrl = (paddr & `C16_APB_SEL_MASK) == `C16_APB_CTRL;

	assign dbg_addr = paddr[`C16_REG_AW:1];

	// Core owns port B whenever it asks
	assign core_busy = core_req.rd | core_req.wr;
	assign grant     = access & is_mem & ~core_busy & ~rd_pend_q;

	// Memory reads finish one cycle after their grant
	assign pready = (access & (is_reg | is_ctrl)) | (grant & pwrite) | rd_pend_q;

	always_comb begin
		if (is_mem) begin
			prdata = b_data;
		end else if (is_reg) begin
			prdata = dbg_val;
		end else if (is_ctrl) begin
			prdata = {{(`C16_WORD_W-1){1'b0}}, run_q};
		end else begin
			prdata = '0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Port B arbiter
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		if (core_busy) begin
			b_addr  = core_req.addr;
			b_wr    = core_req.wr;
			b_wdata = core_req.wdata;
		end else begin
			b_addr  = paddr[`C16_MEM_AW:1];
			b_wr    = grant & pwrite;
			b_wdata = pwdata;
		end
	end

	assign rdata = b_data;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			run_q     <= 1'b0;
			rd_pend_q <= 1'b0;
		end else begin
			if (access & is_ctrl & pwrite) begin
				run_q <= pwdata[0];
			end
			rd_pend_q <= grant & ~pwrite;
		end
	end

	assign run = run_q;

endmodule

/* rtl/c16_top.sv */
`timescale 1ns/1ps
`include "c16_config.svh"

module c16_top (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [`C16_APB_AW-1:0] paddr,
	input  c16_pkg::word_t         pwdata,
	output c16_pkg::word_t         prdata,
	output logic                   pready
);

	c16_pkg::fetch_t    fetch;
	c16_pkg::mem_addr_t next_pc;
	c16_pkg::word_t     instr;
	c16_pkg::reg_addr_t rs_addr;
	c16_pkg::reg_addr_t rt_addr;
	c16_pkg::reg_addr_t dbg_addr;
	c16_pkg::word_t     rs_val;
	c16_pkg::word_t     rt_val;
	c16_pkg::word_t     dbg_val;
	logic               stall;
	logic               run;
	c16_pkg::issue_t    issue;
	c16_pkg::wb_t       wb;
	c16_pkg::mem_req_t  mem_req;
	c16_pkg::word_t     rdata;
	c16_pkg::mem_addr_t b_addr;
	logic               b_wr;
	c16_pkg::word_t     b_wdata;
	c16_pkg::word_t     b_data;

	////////////////////////////////////////////////////////////////////////////
	// Core pipeline
	////////////////////////////////////////////////////////////////////////////

	c16_fetch u_fetch (.clk(clk), .rst_n(rst_n), .run(run), .stall(stall),
		.next_pc(next_pc), .fetch(fetch));

	c16_decode u_decode (.clk(clk), .rst_n(rst_n), .run(run), .fetch(fetch),
		.instr(instr), .rs_addr(rs_addr), .rt_addr(rt_addr), .rs_val(rs_val),
		.rt_val(rt_val), .stall(stall), .issue(issue));

	c16_execute u_execute (.clk(clk), .rst_n(rst_n), .issue(issue),
		.mem_rdata(rdata), .wb(wb), .mem_req(mem_req));

	c16_regfile u_regfile (.clk(clk), .rst_n(rst_n), .rs_addr(rs_addr),
		.rt_addr(rt_addr), .dbg_addr(dbg_addr), .wb(wb), .rs_val(rs_val),
		.rt_val(rt_val), .dbg_val(dbg_val));

	// Memory and host share port B
	c16_mem u_mem (.clk(clk), .a_addr(next_pc), .a_data(instr), .b_addr(b_addr),
		.b_wr(b_wr), .b_wdata(b_wdata), .b_data(b_data));

	c16_host_port u_host (.clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable),
		.pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
		.pready(pready), .run(run), .core_req(mem_req), .rdata(rdata),
		.b_addr(b_addr), .b_wr(b_wr), .b_wdata(b_wdata), .b_data(b_data),
		.dbg_addr(dbg_addr), .dbg_val(dbg_val));

endmodule

/* bench/c16_assert.sv */
`timescale 1ns/1ps
`include "c16_config.svh"

module c16_assert (
	input logic         clk,
	input logic         rst_n,
	input logic         psel,
	input logic         penable,
	input logic         pready,
	input logic         core_wr,
	input logic         host_wr,
	input logic         load_exec,
	input c16_pkg::wb_t wb
);

	// pready only inside an access phase
	a_ready_in_access: assert property (@(posedge clk) disable iff (!rst_n)
		pready |-> (psel && penable))
		else $error("pready outside an APB access phase");

	a_single_writer: assert property (@(posedge clk) disable iff (!rst_n)
		!(core_wr && host_wr))
		else $error("core and host wrote port B in the same cycle");

	// Write-back in the cycle after a load never targets the scratch register
	a_load_dest: assert property (@(posedge clk) disable iff (!rst_n)
		($past(load_exec) && wb.en) |-> (wb.dest != `C16_SCRATCH_REG))
		else $error("load write-back to the scratch register");

endmodule

/* bench/c16_tb.sv */
`timescale 1ns/1ps
`include "c16_config.svh"

module c16_tb;

	localparam int PERIOD     = 100;
	localparam int PROG_LEN   = 41;
	localparam int RUN_CYCLES = 80;
	// Cycle budgets per test
	// An APB access costs about four cycles
	localparam int T1_CYCLES  = 60;
	localparam int T2_CYCLES  = 560;
	localparam int T3_CYCLES  = 1200;
	localparam int T4_CYCLES  = 160;
	localparam int T5_CYCLES  = 1400;
	localparam int BUDGET     = T1_CYCLES + T2_CYCLES + T3_CYCLES + T4_CYCLES + T5_CYCLES;
	localparam logic [`C16_APB_AW-1:0] CTRL_ADDR = `C16_APB_CTRL;

	logic                   clk = 1'b0;
	logic                   rst_n;
	logic                   psel;
	logic                   penable;
	logic                   pwrite;
	logic [`C16_APB_AW-1:0] paddr;
	c16_pkg::word_t         pwdata;
	c16_pkg::word_t         prdata;
	logic                   pready;

	logic [31:0]    lfsr_state = 32'd81535;
	int             cyc = 0;
	int             errors = 0;
	int             checks = 0;
	int             tests = 0;
	int             test_errs = 0;
	c16_pkg::word_t model_mem [256];
	c16_pkg::word_t model_regs [8];

	always #(PERIOD / 2) clk = ~clk;

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	c16_top u_dut (.clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable),
		.pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
		.pready(pready));

	bind c16_top c16_assert u_assert (.clk(clk), .rst_n(rst_n), .psel(psel),
		.penable(penable), .pready(pready), .core_wr(mem_req.wr),
		.host_wr(psel & penable & pwrite & pready & ~paddr[`C16_APB_AW-1]),
		.load_exec(issue.op == c16_pkg::EX_LOAD), .wb(wb));

	////////////////////////////////////////////////////////////////////////////
	// Random source and checking
	////////////////////////////////////////////////////////////////////////////

	// Galois LFSR, one step per bit
	function automatic logic next_bit();
		logic b;
		b = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (b) begin
			lfsr_state = lfsr_state ^ 32'hA300_0000;
		end
		return b;
	endfunction

	function automatic c16_pkg::word_t rand_bits(input int n);
		c16_pkg::word_t v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[14:0], next_bit()};
		end
		return v;
	endfunction

	task automatic compare(input string name, input c16_pkg::word_t exp,
		input c16_pkg::word_t act);
		checks++;
		if (exp !== act) begin
			$display("FAIL %s expected %h actual %h", name, exp, act);
			errors++;
			test_errs++;
		end
	endtask

	task automatic finish_test(input string name);
		tests++;
		if (test_errs == 0) begin
			$display("test %0d %s: ok", tests, name);
		end else begin
			$display("test %0d %s: %0d mismatches", tests, name, test_errs);
		end
		test_errs = 0;
	endtask

	// Reset the DUT and clear the register model
	task automatic apply_reset();
		rst_n = 1'b0;
		for (int r = 0; r < 8; r++) begin
			model_regs[r] = '0;
		end
		repeat (5) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// APB host accesses
	////////////////////////////////////////////////////////////////////////////

	task automatic access_bus(input logic wr, input logic [`C16_APB_AW-1:0] addr,
		input c16_pkg::word_t wdata, output c16_pkg::word_t rdata);
		logic done;
		@(negedge clk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(negedge clk);
		penable = 1'b1;
		done    = 1'b0;
		// Sample a quarter period after the drive edge
		while (!done) begin
			#(PERIOD / 4);
			done  = pready;
			rdata = prdata;
			@(negedge clk);
		end
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic write_word(input logic [`C16_APB_AW-1:0] addr, input c16_pkg::word_t data);
		c16_pkg::word_t unused;
		access_bus(1'b1, addr, data, unused);
	endtask

	task automatic read_word(input logic [`C16_APB_AW-1:0] addr, output c16_pkg::word_t data);
		access_bus(1'b0, addr, '0, data);
	endtask

	function automatic logic [`C16_APB_AW-1:0] mem_paddr(input int w);
		return `C16_APB_MEM | `C16_APB_AW'(w * 2);
	endfunction

	function automatic logic [`C16_APB_AW-1:0] reg_paddr(input int r);
		return `C16_APB_REG | `C16_APB_AW'(r * 2);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Program generation and reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic c16_pkg::word_t make_instr();
		c16_pkg::word_t kind;
		c16_pkg::word_t f;
		c16_pkg::word_t rd;
		c16_pkg::word_t rs;
		c16_pkg::word_t imm;
		logic [3:0]     op;
		kind = rand_bits(3);
		f    = rand_bits(1);
		rd   = rand_bits(3);
		rs   = rand_bits(3);
		imm  = rand_bits(5);
		// r6 holds the data base, so it never takes a write
		if (rd == 16'd6) begin
			rd = 16'd7;
		end
		case (kind)
			16'd1: op = `C16_OP_SUB;
			16'd2: op = `C16_OP_SLT;
			16'd3: op = `C16_OP_SHL;
			16'd4: op = `C16_OP_LEA;
			16'd5: op = `C16_OP_LD;
			16'd6: op = `C16_OP_ST;
			default: op = `C16_OP_ADD;
		endcase
		if (op == `C16_OP_LD || op == `C16_OP_ST) begin
			f  = '0;
			rs = 16'd6;
		end
		if (op == `C16_OP_ST) begin
			rd = rand_bits(3);
		end
		return {op, f[0], rd[2:0], rs[2:0], imm[4:0]};
	endfunction

	function automatic c16_pkg::word_t reg_value(input logic [2:0] r);
		return (r == `C16_SCRATCH_REG) ? 16'h0000 : model_regs[r];
	endfunction

	task automatic step_model(input int pc);
		c16_pkg::word_t w;
		c16_pkg::word_t i5;
		c16_pkg::word_t i8;
		c16_pkg::word_t a;
		c16_pkg::word_t b;
		c16_pkg::word_t res;
		c16_pkg::word_t ea;
		logic           wr_reg;
		w      = model_mem[pc];
		i5     = {{11{w[4]}}, w[4:0]};
		i8     = {{8{w[7]}}, w[7:0]};
		a      = reg_value(w[7:5]);
		b      = w[11] ? reg_value(w[2:0]) : i5;
		ea     = w[11] ? 16'(pc) + i8 : a + i5;
		wr_reg = 1'b1;
		res    = '0;
		case (w[15:12])
			`C16_OP_ADD: res = a + b;
			`C16_OP_SUB: res = a - b;
			`C16_OP_SLT: res = (a < b) ? 16'd1 : 16'd0;
			`C16_OP_SHL: res = a << i5[3:0];
			`C16_OP_LEA: res = ea;
			`C16_OP_LD:  res = model_mem[ea[7:0]];
			`C16_OP_ST: begin
				model_mem[ea[7:0]] = reg_value(w[10:8]);
				wr_reg = 1'b0;
			end
			default: wr_reg = 1'b0;
		endcase
		if (wr_reg && w[10:8] != `C16_SCRATCH_REG) begin
			model_regs[w[10:8]] = res;
		end
	endtask

	task automatic load_program();
		model_mem[0] = {`C16_OP_LEA, 1'b1, 3'd6, 8'd112};
		for (int i = 1; i < 256; i++) begin
			if (i < PROG_LEN) begin
				model_mem[i] = make_instr();
			end else if (i >= 96 && i < 128) begin
				model_mem[i] = rand_bits(16);
			end else begin
				model_mem[i] = '0;
			end
		end
		for (int i = 0; i < 256; i++) begin
			write_word(mem_paddr(i), model_mem[i]);
		end
	endtask

	// Start the core, optionally read program words while it runs, then halt it
	task automatic run_core(input logic with_reads);
		c16_pkg::word_t v;
		int             start;
		int             idx;
		write_word(CTRL_ADDR, 16'd1);
		start = cyc;
		idx   = 0;
		if (with_reads) begin
			while (cyc - start < RUN_CYCLES) begin
				read_word(mem_paddr(idx), v);
				compare($sformatf("image word %0d", idx), model_mem[idx], v);
				idx = (idx + 1) % PROG_LEN;
			end
		end else begin
			repeat (RUN_CYCLES) @(negedge clk);
		end
		write_word(CTRL_ADDR, 16'd0);
		repeat (4) @(negedge clk);
	endtask

	task automatic check_regs();
		c16_pkg::word_t v;
		for (int r = 0; r < 8; r++) begin
			read_word(reg_paddr(r), v);
			compare($sformatf("r%0d", r), reg_value(3'(r)), v);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		c16_pkg::word_t v;
		c16_pkg::word_t data [64];
		rst_n   = 1'b0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		apply_reset();

		check_regs();
		read_word(CTRL_ADDR, v);
		compare("ctrl", 16'h0000, v);
		finish_test("reset state");

		for (int i = 0; i < 64; i++) begin
			data[i] = rand_bits(16);
			write_word(mem_paddr(64 + i), data[i]);
		end
		for (int i = 0; i < 64; i++) begin
			read_word(mem_paddr(64 + i), v);
			compare($sformatf("mem %0d", 64 + i), data[i], v);
		end
		finish_test("memory readback");

		load_program();
		for (int pc = 0; pc < PROG_LEN; pc++) begin
			step_model(pc);
		end
		run_core(1'b0);
		check_regs();
		finish_test("random program");

		for (int i = 96; i < 128; i++) begin
			read_word(mem_paddr(i), v);
			compare($sformatf("store %0d", i), model_mem[i], v);
		end
		finish_test("stored words");

		// Second program starts from the reset PC with cleared registers
		apply_reset();
		load_program();
		for (int pc = 0; pc < PROG_LEN; pc++) begin
			step_model(pc);
		end
		run_core(1'b1);
		check_regs();
		finish_test("port B contention");

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	initial begin
		repeat (2 * BUDGET) @(posedge clk);
		$display("Timeout, the tests did not finish within their cycle budget");
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* sources.f */
+incdir+rtl
rtl/c16_pkg.sv
rtl/c16_fetch.sv
rtl/c16_decode.sv
rtl/c16_execute.sv
rtl/c16_regfile.sv
rtl/c16_mem.sv
rtl/c16_host_port.sv
rtl/c16_top.sv
bench/c16_assert.sv
bench/c16_tb.sv

/* run.sh */
#!/bin/sh
# Build and run with Verilator, then decide on the log contents
verilator --binary --timing --assert -f sources.f --top-module c16_tb -o c16_sim \
	&& ./obj_dir/c16_sim | tee sim.log \
	&& ! grep -q "TESTBENCH FAILED" sim.log \
	&& grep -q "TESTBENCH PASSED" sim.log \
	|| { echo "simulation failed"; exit 1; }
